// ==== hdl/regfile_config.svh ====
/*
 * register file configuration
 * word width, register count and the read mode used when a read
 * and the write hit the same address in the same cycle
 */

`ifndef REGFILE_CONFIG_SVH
`define REGFILE_CONFIG_SVH

// data word width in bits
`define REGFILE_WIDTH 16

// number of registers in the file
`define REGFILE_ELS 16

// 1 gives write-then-read on a same-address collision
`define REGFILE_RW_SAME_ADDR 1

`endif

// ==== hdl/regfile_pkg.sv ====
/*
 * register file package
 * vector types for data, register index and immediate,
 * and the operation codes of the execution unit
 */

`include "regfile_config.svh"

package regfile_pkg;

   // a single register still needs one address bit
   localparam int addr_w = (`REGFILE_ELS > 1) ? $clog2(`REGFILE_ELS) : 1;

   typedef logic [`REGFILE_WIDTH-1:0] data_t;
   typedef logic [addr_w-1:0]         addr_t;

   // immediate is full width so op_ldi can set any value
   typedef logic [`REGFILE_WIDTH-1:0] imm_t;

   // operation codes carried by the command strobe
   typedef enum logic [2:0]
   {
      op_add = 3'd0,
      op_sub = 3'd1,
      op_and = 3'd2,
      op_xor = 3'd3,
      op_ldi = 3'd4
   } alu_op_t;

endpackage

// ==== hdl/mem_port_if.sv ====
/*
 * register file port bundle
 * one write port and two synchronous read ports between the
 * execution stage and the RAM
 */

`timescale 1ns/1ns

interface mem_port_if;

   import regfile_pkg::*;

   // write port
   logic  w_v;
   addr_t w_addr;
   data_t w_data;

   // read port 0
   logic  r0_v;
   addr_t r0_addr;
   data_t r0_data;

   // read port 1
   logic  r1_v;
   addr_t r1_addr;
   data_t r1_data;

   // execution side drives requests and write data
   modport exec
   (
      output w_v, w_addr, w_data,
      output r0_v, r0_addr,
      output r1_v, r1_addr,
      input  r0_data, r1_data
   );

   // memory side answers with read data
   modport mem
   (
      input  w_v, w_addr, w_data,
      input  r0_v, r0_addr,
      input  r1_v, r1_addr,
      output r0_data, r1_data
   );

endinterface

// ==== hdl/mem_2r1w_sync_synth.sv ====
/*
 * two-read one-write synchronous RAM storage
 * word array with registered read ports, optional forwarding of
 * the write data to a read of the same address
 */

`timescale 1ns/1ns

`include "regfile_config.svh"

module mem_2r1w_sync_synth
#(
   parameter int rw_same_addr_p = 0
)
(
   input logic    clk_i,
   input logic    rst_i,
   mem_port_if.mem mem
);

   import regfile_pkg::*;

   data_t ram_r [`REGFILE_ELS];
   data_t r0_data_r;
   data_t r1_data_r;
   logic  wr_en;

   // no stray write may land while reset is held
   assign wr_en = mem.w_v & ~rst_i;

   // word seen by a read issued at this edge
   function automatic data_t read_word(input addr_t addr);
      if ((rw_same_addr_p != 0) && wr_en && (addr == mem.w_addr))
      begin
         return mem.w_data;
      end
      return ram_r[addr];
   endfunction

   always_ff @(posedge clk_i)
   begin
      if (wr_en)
      begin
         ram_r[mem.w_addr] <= mem.w_data;
      end
   end

   // read data holds until the next valid read on the same port
   always_ff @(posedge clk_i)
   begin
      if (mem.r0_v)
      begin
         r0_data_r <= read_word(mem.r0_addr);
      end
      if (mem.r1_v)
      begin
         r1_data_r <= read_word(mem.r1_addr);
      end
   end

   assign mem.r0_data = r0_data_r;
   assign mem.r1_data = r1_data_r;

endmodule

// ==== hdl/mem_2r1w_sync.sv ====
/*
 * two-read one-write synchronous RAM
 * memory block of the register file, keeps the port definition
 * apart from the storage so a hardened array can take its place
 */

`timescale 1ns/1ns

`include "regfile_config.svh"

module mem_2r1w_sync
(
   input logic     clk_i,
   input logic     rst_i,
   mem_port_if.mem mem
);

   // same-address read mode taken from the configuration
   localparam int rw_same_addr_lp = `REGFILE_RW_SAME_ADDR;

   // reads are synchronous, data follows the sampling edge
   // a colliding read returns the new word when forwarding is on
   mem_2r1w_sync_synth
   #(
      .rw_same_addr_p (rw_same_addr_lp)
   )
   synth
   (
      .clk_i (clk_i),
      .rst_i (rst_i),
      .mem   (mem)
   );

endmodule

// ==== hdl/alu_exec.sv ====
/*
 * register file execution stage
 * issues source reads on the command strobe, computes the result
 * one cycle later, writes it back and registers it to the output
 */

`timescale 1ns/1ns

module alu_exec
(
   input  logic                 clk_i,
   input  logic                 rst_i,

   input  logic                 cmd_v_i,
   input  regfile_pkg::alu_op_t cmd_op_i,
   input  regfile_pkg::addr_t   cmd_rs0_i,
   input  regfile_pkg::addr_t   cmd_rs1_i,
   input  regfile_pkg::addr_t   cmd_rd_i,
   input  regfile_pkg::imm_t    cmd_imm_i,

   mem_port_if.exec             mem,

   output logic                 res_v_o,
   output regfile_pkg::addr_t   res_rd_o,
   output regfile_pkg::data_t   res_data_o
);

   import regfile_pkg::*;

   // stage 1 command state
   logic    s1_v_r;
   alu_op_t s1_op_r;
   addr_t   s1_rd_r;
   imm_t    s1_imm_r;

   // result of the stage 1 command
   data_t   result;

   // output register
   logic    res_v_r;
   addr_t   res_rd_r;
   data_t   res_data_r;

   // load immediate needs no source operands
   logic    need_rd;

   assign need_rd = cmd_v_i && (cmd_op_i != op_ldi);

   // source reads go out in the strobe cycle
   assign mem.r0_v    = need_rd;
   assign mem.r0_addr = cmd_rs0_i;
   assign mem.r1_v    = need_rd;
   assign mem.r1_addr = cmd_rs1_i;

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         s1_v_r <= 1'b0;
      end
      else
      begin
         s1_v_r <= cmd_v_i;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (cmd_v_i)
      begin
         s1_op_r  <= cmd_op_i;
         s1_rd_r  <= cmd_rd_i;
         s1_imm_r <= cmd_imm_i;
      end
   end

   // arithmetic wraps at the word width
   always_comb
   begin
      case (s1_op_r)
         op_add:  result = mem.r0_data + mem.r1_data;
         op_sub:  result = mem.r0_data - mem.r1_data;
         op_and:  result = mem.r0_data & mem.r1_data;
         op_xor:  result = mem.r0_data ^ mem.r1_data;
         op_ldi:  result = s1_imm_r;
         default: result = '0;
      endcase
   end

   // write back in stage 1, the next command can read it at the same edge
   assign mem.w_v    = s1_v_r;
   assign mem.w_addr = s1_rd_r;
   assign mem.w_data = result;

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         res_v_r <= 1'b0;
      end
      else
      begin
         res_v_r <= s1_v_r;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (s1_v_r)
      begin
         res_rd_r   <= s1_rd_r;
         res_data_r <= result;
      end
   end

   assign res_v_o    = res_v_r;
   assign res_rd_o   = res_rd_r;
   assign res_data_o = res_data_r;

endmodule

// ==== hdl/regfile_alu_top.sv ====
/*
 * register file execution unit
 * accepts one command per cycle, reads two registers, writes the
 * result back and reports it two cycles after the strobe
 */

`timescale 1ns/1ns

module regfile_alu_top
(
   input  logic                 clk_i,
   input  logic                 rst_i,

   // command strobe, fields valid only with cmd_v_i
   input  logic                 cmd_v_i,
   input  regfile_pkg::alu_op_t cmd_op_i,
   input  regfile_pkg::addr_t   cmd_rs0_i,
   input  regfile_pkg::addr_t   cmd_rs1_i,
   input  regfile_pkg::addr_t   cmd_rd_i,
   input  regfile_pkg::imm_t    cmd_imm_i,

   // single-cycle result strobe
   output logic                 res_v_o,
   output regfile_pkg::addr_t   res_rd_o,
   output regfile_pkg::data_t   res_data_o
);

   mem_port_if mem_if ();

   alu_exec u_exec
   (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .cmd_v_i    (cmd_v_i),
      .cmd_op_i   (cmd_op_i),
      .cmd_rs0_i  (cmd_rs0_i),
      .cmd_rs1_i  (cmd_rs1_i),
      .cmd_rd_i   (cmd_rd_i),
      .cmd_imm_i  (cmd_imm_i),
      .mem        (mem_if.exec),
      .res_v_o    (res_v_o),
      .res_rd_o   (res_rd_o),
      .res_data_o (res_data_o)
   );

   // register storage, write-then-read on collisions
   mem_2r1w_sync u_mem
   (
      .clk_i (clk_i),
      .rst_i (rst_i),
      .mem   (mem_if.mem)
   );

endmodule

// ==== testbench/regfile_alu_assert.sv ====
/*
 * RAM port assertions
 * address range on every port, read data hold between valid reads
 * and an idle write port right after reset
 */

`timescale 1ns/1ns

`include "regfile_config.svh"

module regfile_alu_assert
(
   input logic               clk_i,
   input logic               rst_i,
   input logic               w_v,
   input regfile_pkg::addr_t w_addr,
   input logic               r0_v,
   input regfile_pkg::addr_t r0_addr,
   input regfile_pkg::data_t r0_data,
   input logic               r1_v,
   input regfile_pkg::addr_t r1_addr,
   input regfile_pkg::data_t r1_data
);

   import regfile_pkg::*;

   // every active port addresses an existing register
   a_waddr_range: assert property (@(posedge clk_i) disable iff (rst_i)
      w_v |-> (int'(w_addr) < `REGFILE_ELS))
      else $error("write address out of range");

   a_raddr_range: assert property (@(posedge clk_i) disable iff (rst_i)
      (!r0_v || (int'(r0_addr) < `REGFILE_ELS)) && (!r1_v || (int'(r1_addr) < `REGFILE_ELS)))
      else $error("read address out of range");

   // read data moves only after a valid read on its own port
   a_r0_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      !$past(r0_v) |-> $stable(r0_data))
      else $error("read port 0 data changed without a read");

   a_r1_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      !$past(r1_v) |-> $stable(r1_data))
      else $error("read port 1 data changed without a read");

   // stage 1 is empty when reset goes away
   a_w_idle_after_reset: assert property (@(posedge clk_i)
      $fell(rst_i) |-> !w_v)
      else $error("write port active in the first cycle after reset");

endmodule

// ==== testbench/regfile_alu_tb.sv ====
/*
 * testbench for the register file execution unit
 * seeded random commands checked against a register model,
 * with latency, idle gap and back-to-back dependency checks
 */

`timescale 1ns/1ns

`include "regfile_config.svh"

// RAM port assertions ride along with the memory block
bind mem_2r1w_sync regfile_alu_assert u_assert
(
   .clk_i   (clk_i),
   .rst_i   (rst_i),
   .w_v     (mem.w_v),
   .w_addr  (mem.w_addr),
   .r0_v    (mem.r0_v),
   .r0_addr (mem.r0_addr),
   .r0_data (mem.r0_data),
   .r1_v    (mem.r1_v),
   .r1_addr (mem.r1_addr),
   .r1_data (mem.r1_data)
);

module regfile_alu_tb;

   import regfile_pkg::*;

   localparam time clk_period = 40;
   localparam int  n_random   = 400;
   localparam int  n_chains   = 4;
   localparam int  chain_len  = 6;
   localparam int  drain_max  = 50;

   logic    clk_i = 1'b0;
   logic    rst_i;
   logic    cmd_v_i;
   alu_op_t cmd_op_i;
   addr_t   cmd_rs0_i;
   addr_t   cmd_rs1_i;
   addr_t   cmd_rd_i;
   imm_t    cmd_imm_i;
   logic    res_v_o;
   addr_t   res_rd_o;
   data_t   res_data_o;

   integer  seed = 32'h1ea8_396a;
   int      err_cnt = 0;
   int      check_cnt = 0;

   // register model and the results still expected from the DUT
   data_t   model [`REGFILE_ELS];
   addr_t   exp_rd_q [$];
   data_t   exp_data_q [$];
   time     exp_t_q [$];

   regfile_alu_top uut
   (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .cmd_v_i    (cmd_v_i),
      .cmd_op_i   (cmd_op_i),
      .cmd_rs0_i  (cmd_rs0_i),
      .cmd_rs1_i  (cmd_rs1_i),
      .cmd_rd_i   (cmd_rd_i),
      .cmd_imm_i  (cmd_imm_i),
      .res_v_o    (res_v_o),
      .res_rd_o   (res_rd_o),
      .res_data_o (res_data_o)
   );

   always #(clk_period/2) clk_i = ~clk_i;

   task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
      check_cnt++;
      if (got !== exp)
      begin
         err_cnt++;
         $display("CHECK FAILED at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
      end
   endtask

   function automatic int rand_range(input int n);
      return int'($unsigned($random(seed)) % n);
   endfunction

   // operation rules, all arithmetic wraps at the word width
   function automatic data_t expect_result(input alu_op_t op, input data_t a, input data_t b,
                                           input imm_t imm);
      case (op)
         op_add:  return a + b;
         op_sub:  return a - b;
         op_and:  return a & b;
         op_xor:  return a ^ b;
         default: return imm;
      endcase
   endfunction

   // one strobe on the next rising edge, model updated in command order
   task automatic issue_cmd(input alu_op_t op, input addr_t rs0, input addr_t rs1,
                            input addr_t rd, input imm_t imm);
      data_t res;
      @(posedge clk_i);
      res = expect_result(op, model[rs0], model[rs1], imm);
      model[rd] = res;
      exp_rd_q.push_back(rd);
      exp_data_q.push_back(res);
      exp_t_q.push_back($time);
      cmd_v_i   <= 1'b1;
      cmd_op_i  <= op;
      cmd_rs0_i <= rs0;
      cmd_rs1_i <= rs1;
      cmd_rd_i  <= rd;
      cmd_imm_i <= imm;
   endtask

   task automatic idle_cycles(input int n);
      repeat (n)
      begin
         @(posedge clk_i);
         cmd_v_i <= 1'b0;
      end
   endtask

   task automatic wait_drain();
      int waited;
      waited = 0;
      while ((exp_rd_q.size() != 0) && (waited < drain_max))
      begin
         @(posedge clk_i);
         cmd_v_i <= 1'b0;
         waited++;
      end
      if (exp_rd_q.size() != 0)
      begin
         err_cnt++;
         $display("timeout: %0d results still missing after %0d cycles",
                  exp_rd_q.size(), waited);
      end
   endtask

   // outputs are registered, so the falling edge sees them settled
   always @(negedge clk_i)
   begin
      if (!rst_i && (res_v_o !== 1'b0))
      begin
         if (exp_rd_q.size() == 0)
         begin
            err_cnt++;
            $display("error at %0t ns: result strobe with no command outstanding", $time);
         end
         else
         begin
            check("res_rd_o", 64'(res_rd_o), 64'(exp_rd_q.pop_front()));
            check("res_data_o", 64'(res_data_o), 64'(exp_data_q.pop_front()));
            check("result latency", $time - exp_t_q.pop_front(),
                  64'(2*clk_period + clk_period/2));
         end
      end
   end

   initial
   begin : stimulus
      int      i;
      int      c;
      alu_op_t op;
      addr_t   rs0;
      addr_t   rs1;
      addr_t   rd;
      imm_t    imm;

      rst_i     = 1'b1;
      cmd_v_i   = 1'b0;
      cmd_op_i  = op_add;
      cmd_rs0_i = '0;
      cmd_rs1_i = '0;
      cmd_rd_i  = '0;
      cmd_imm_i = '0;

      // 8 reset cycles, then two quiet cycles before the first strobe
      for (i = 0; i < 10; i++)
      begin
         @(posedge clk_i);
         if (i == 7)
         begin
            rst_i <= 1'b0;
         end
         @(negedge clk_i);
         check("res_v_o around reset", 64'(res_v_o), 64'(0));
      end

      for (i = 0; i < `REGFILE_ELS; i++)
      begin
         imm = data_t'($random(seed));
         issue_cmd(op_ldi, '0, '0, addr_t'(i), imm);
      end
      idle_cycles(5);

      for (i = 0; i < n_random; i++)
      begin
         if (rand_range(3) == 0)
         begin
            idle_cycles(1 + rand_range(3));
         end
         op  = alu_op_t'(rand_range(5));
         rs0 = addr_t'(rand_range(`REGFILE_ELS));
         rs1 = addr_t'(rand_range(`REGFILE_ELS));
         rd  = addr_t'(rand_range(`REGFILE_ELS));
         imm = data_t'($random(seed));
         issue_cmd(op, rs0, rs1, rd, imm);
      end
      idle_cycles(4);

      // each command reads the destination written just before it
      for (c = 0; c < n_chains; c++)
      begin
         rd  = addr_t'(rand_range(`REGFILE_ELS));
         imm = data_t'($random(seed));
         issue_cmd(op_ldi, '0, '0, rd, imm);
         for (i = 0; i < chain_len; i++)
         begin
            rs0 = rd;
            // add and and keep the forwarded value visible in the result
            op  = (rand_range(2) == 0) ? op_add : op_and;
            rd  = addr_t'(rand_range(`REGFILE_ELS));
            issue_cmd(op, rs0, rs0, rd, '0);
         end
         idle_cycles(1 + rand_range(4));
      end

      wait_drain();
      // a quiet tail catches stray strobes
      idle_cycles(6);

      $display("checks: %0d, errors: %0d", check_cnt, err_cnt);
      if (err_cnt == 0)
      begin
         $display("RESULT: PASS");
      end
      else
      begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

// ==== vlog.f ====
+incdir+hdl
hdl/regfile_pkg.sv
hdl/mem_port_if.sv
hdl/mem_2r1w_sync_synth.sv
hdl/mem_2r1w_sync.sv
hdl/alu_exec.sv
hdl/regfile_alu_top.sv
testbench/regfile_alu_assert.sv
testbench/regfile_alu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the register file testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ns \
      --top-module regfile_alu_tb -f vlog.f -o regfile_alu_sim
then
   echo "compile failed"
   exit 1
fi

sim_out=$(./obj_dir/regfile_alu_sim 2>&1)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if echo "$sim_out" | grep -q "^RESULT: PASS$"; then
   exit 0
fi

echo "pass message not found in simulation output"
exit 1
